// ==== filelist.f ====
+incdir+include
logic/expander_pkg.sv
logic/shadow_register.sv
logic/update_sequencer.sv
logic/parallel2serial.sv
logic/output_expander.sv
bench/shift_chain_model.sv
bench/output_expander_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
	-f filelist.f \
	--top-module output_expander_tb \
	-o output_expander_sim

# the simulator exits non-zero on a fatal check, the grep decides
out=$(./obj_dir/output_expander_sim || true)
echo "$out"

if echo "$out" | grep -q "TESTBENCH PASSED"; then
	echo "simulation result: pass"
	exit 0
else
	echo "simulation result: fail"
	exit 1
fi

// ==== bench/output_expander_tb.sv ====
// output expander testbench
`timescale 1ns/1ps
`default_nettype none
`include "expander_settings.svh"

module output_expander_tb
	import expander_pkg::*;
();

	localparam int W              = `EXP_DATA_BITS;
	localparam int XFER_CYCLES    = 350; // clear, all bits, latch, handshakes
	localparam int MAX_XFERS      = 40;
	localparam int TIMEOUT_CYCLES = XFER_CYCLES * MAX_XFERS + 6000;

	logic         clk = 1'b0;
	logic         rst;
	logic         cmd_valid;
	exp_op_t      cmd_op;
	logic [W-1:0] cmd_arg;
	wire  [W-1:0] image;
	wire          pending;
	wire          s_clk;
	wire          s_clr;
	wire          s_dat;
	wire          s_lat;
	wire  [W-1:0] pins;
	wire  [31:0]  latch_count;
	wire          proto_err;

	logic [W-1:0] ref_img; // expected pin image
	logic [31:0]  rng;
	int           cycles = 0;

	output_expander dut0 (
		.clk       (clk),
		.rst       (rst),
		.cmd_valid (cmd_valid),
		.cmd_op    (cmd_op),
		.cmd_arg   (cmd_arg),
		.image     (image),
		.pending   (pending),
		.s_clk     (s_clk),
		.s_clr     (s_clr),
		.s_dat     (s_dat),
		.s_lat     (s_lat)
	);

	shift_chain_model chain0 (
		.s_clk       (s_clk),
		.s_clr       (s_clr),
		.s_dat       (s_dat),
		.s_lat       (s_lat),
		.pins        (pins),
		.latch_count (latch_count),
		.proto_err   (proto_err)
	);

	always #50 clk = ~clk;

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	task automatic compare(input string name, input logic [W-1:0] got,
		input logic [W-1:0] exp);
		if (got !== exp) begin
			fail_now($sformatf("** Error at %0t ns: %s is %h, expected %h",
				$time, name, got, exp));
		end
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			fail_now($sformatf("timeout after %0d cycles with the sequencer in %s",
				cycles, dut0.u_seq.state.name()));
		end
	end

	always @(posedge proto_err) begin
		fail_now("serial clock rose during the storage latch pulse");
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// opcode rules of the host command port
	function automatic logic [W-1:0] next_image(input logic [W-1:0] img,
		input exp_op_t op, input logic [W-1:0] arg);
		case (op)
			OP_WRITE: return arg;
			OP_SET:   return img | arg;
			OP_CLEAR: return img & ~arg;
			default:  return img ^ arg; // toggle
		endcase
	endfunction

	// entered and left on a falling edge
	task automatic issue_cmd(input exp_op_t op, input logic [W-1:0] arg);
		cmd_valid = 1'b1;
		cmd_op    = op;
		cmd_arg   = arg;
		ref_img   = next_image(ref_img, op, arg);
		@(negedge clk);
		cmd_valid = 1'b0;
	endtask

	task automatic wait_idle();
		while (pending) begin
			@(negedge clk);
		end
	endtask

	task automatic wait_clear();
		while (!s_clr) begin
			@(negedge clk);
		end
	endtask

	task automatic apply_and_verify(input exp_op_t op, input logic [W-1:0] arg);
		issue_cmd(op, arg);
		wait_idle();
		compare("image", image, ref_img);
		compare("pins", pins, ref_img);
	endtask

	task automatic after_reset();
		compare("s_clk", W'(s_clk), '0);
		compare("s_clr", W'(s_clr), '0);
		compare("s_lat", W'(s_lat), '0);
		compare("pending", W'(pending), '0);
		compare("image", image, '0);
		compare("latch_count", latch_count, '0);
	endtask

	task automatic write_whole_word();
		logic [31:0] base;
		base = latch_count;
		apply_and_verify(OP_WRITE, 32'ha5c3_0f81);
		compare("image", image, 32'ha5c3_0f81);
		compare("latch_count", latch_count, base + 32'd1);
	endtask

	task automatic run_mask_ops();
		apply_and_verify(OP_SET, 32'h0000_ff00);
		apply_and_verify(OP_CLEAR, 32'ha000_0001);
		apply_and_verify(OP_TOGGLE, 32'hffff_0000);
	endtask

	// ten commands while a shift is under way
	task automatic coalesce_burst();
		logic [31:0] base;
		logic [31:0] delta;
		issue_cmd(OP_WRITE, 32'h1234_5678);
		wait_clear();
		base = latch_count;
		for (int i = 0; i < 10; i++) begin
			rng = xorshift32(rng);
			issue_cmd(exp_op_t'(2'(i)), rng);
		end
		wait_idle();
		delta = latch_count - base;
		compare("pins", pins, ref_img);
		compare("image", image, ref_img);
		if (delta < 32'd1 || delta > 32'd10) begin
			fail_now($sformatf("latch count rose by %0d in the burst, expected 1 to 10",
				delta));
		end
	endtask

	task automatic random_sequence();
		exp_op_t op;
		int      gap;
		for (int n = 0; n < 25; n++) begin
			rng = xorshift32(rng);
			op  = exp_op_t'(rng[1:0]);
			gap = int'(rng[5:4]); // 0 to 3 idle cycles
			rng = xorshift32(rng);
			issue_cmd(op, rng);
			repeat (gap) @(negedge clk);
		end
		wait_idle();
		compare("pins", pins, ref_img);
		compare("image", image, ref_img);
	endtask

	initial begin
		rst       = 1'b1;
		cmd_valid = 1'b0;
		cmd_op    = OP_WRITE;
		cmd_arg   = '0;
		ref_img   = '0;
		rng       = 32'h3ce257b1;
		repeat (4) @(negedge clk); // four rising edges in reset
		rst = 1'b0;
		after_reset();
		write_whole_word();
		run_mask_ops();
		coalesce_burst();
		random_sequence();
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== bench/shift_chain_model.sv ====
// shift register chain model
`timescale 1ns/1ps
`default_nettype none
`include "expander_settings.svh"

module shift_chain_model (
	input  wire                       s_clk,
	input  wire                       s_clr,
	input  wire                       s_dat,
	input  wire                       s_lat,
	output logic [`EXP_DATA_BITS-1:0] pins,
	output logic [31:0]               latch_count,
	output logic                      proto_err
);

	localparam int W = `EXP_DATA_BITS;

	logic [W-1:0] chain = '0;   // serial-in stages
	logic [W-1:0] latched = '0; // storage register
	logic [31:0]  n_latch = '0;
	logic         bad_clk = 1'b0;

	// a rising s_clk inside the clear phase also clears
	always @(posedge s_clk or posedge s_clr) begin
		if (s_clr) begin
			chain <= '0;
		end else if (`EXP_CODE_ENDIAN != 0) begin
			chain <= {chain[W-2:0], s_dat}; // first bit ends at the top
		end else begin
			chain <= {s_dat, chain[W-1:1]}; // first bit ends at bit 0
		end
	end

	always @(posedge s_lat) begin
		latched <= chain;
		n_latch <= n_latch + 32'd1;
	end

	// serial clock must stay parked while the latch is open
	always @(posedge s_clk) begin
		if (s_lat) begin
			$display("shift chain model: s_clk rose while s_lat was high at %0t ns", $time);
			bad_clk <= 1'b1;
		end
	end

	assign pins        = latched;
	assign latch_count = n_latch;
	assign proto_err   = bad_clk;

endmodule

`default_nettype wire

// ==== logic/output_expander.sv ====
// serial output expander top
`timescale 1ns/1ps
`default_nettype none
`include "expander_settings.svh"

module output_expander
	import expander_pkg::*;
(
	input  wire                       clk,
	input  wire                       rst,
	input  wire                       cmd_valid,
	input  wire exp_op_t              cmd_op,
	input  wire [`EXP_DATA_BITS-1:0]  cmd_arg,
	output logic [`EXP_DATA_BITS-1:0] image,
	output logic                      pending,
	output logic                      s_clk,
	output logic                      s_clr,
	output logic                      s_dat,
	output logic                      s_lat
);

	wire                      upd_valid;
	wire                      upd_ready;
	wire [`EXP_DATA_BITS-1:0] upd_data;
	wire [`EXP_DATA_BITS-1:0] frame; // stable word for the engine
	wire                      start;
	wire                      finish;

	shadow_register u_shadow (
		.clk       (clk),
		.rst       (rst),
		.cmd_valid (cmd_valid),
		.cmd_op    (cmd_op),
		.cmd_arg   (cmd_arg),
		.upd_ready (upd_ready),
		.upd_valid (upd_valid),
		.upd_data  (upd_data),
		.image     (image)
	);

	update_sequencer u_seq (
		.clk       (clk),
		.rst       (rst),
		.upd_valid (upd_valid),
		.upd_data  (upd_data),
		.upd_ready (upd_ready),
		.frame     (frame),
		.start     (start),
		.finish    (finish),
		.s_lat     (s_lat),
		.pending   (pending)
	);

	parallel2serial #(
		.P_CLK_FREQ  (`EXP_P_CLK_FREQ),
		.S_CLK_FREQ  (`EXP_S_CLK_FREQ),
		.DATA_BITS   (`EXP_DATA_BITS),
		.CODE_ENDIAN (`EXP_CODE_ENDIAN)
	) u_p2s (
		.clk    (clk),
		.rst    (rst),
		.data   (frame),
		.start  (start),
		.busy   (), // sequencer tracks finish instead
		.finish (finish),
		.s_clk  (s_clk),
		.s_clr  (s_clr),
		.s_dat  (s_dat)
	);

endmodule

`default_nettype wire

// ==== logic/parallel2serial.sv ====
// parallel to serial shift engine
`timescale 1ns/1ps
`default_nettype none

module parallel2serial #(
	parameter int P_CLK_FREQ  = 100, // main clock, MHz
	parameter int S_CLK_FREQ  = 10,  // serial clock, MHz
	parameter int DATA_BITS   = 32,
	parameter int CODE_ENDIAN = 0    // 1 sends msb first
) (
	input  wire                 clk,
	input  wire                 rst,
	input  wire [DATA_BITS-1:0] data,
	input  wire                 start,
	output logic                busy,
	output logic                finish,
	output logic                s_clk,
	output logic                s_clr,
	output logic                s_dat
);

	localparam int HALF   = 1 + (P_CLK_FREQ - 1) / S_CLK_FREQ / 2; // main clocks per half period
	localparam int CCNT_W = (HALF > 1) ? $clog2(HALF) : 1;
	localparam int DCNT_W = (DATA_BITS > 1) ? $clog2(DATA_BITS) : 1;
	localparam logic [CCNT_W-1:0] CCNT_LAST = CCNT_W'(HALF - 1);
	localparam logic [DCNT_W-1:0] DCNT_LAST = DCNT_W'(DATA_BITS - 1);

	typedef enum logic [1:0] {
		P2S_IDLE  = 2'd0,
		P2S_CLEAR = 2'd1, // s_clr high for one serial period
		P2S_WORK  = 2'd2, // shifting data out
		P2S_DONE  = 2'd3  // finish pulse
	} p2s_state_t;

	p2s_state_t        state;
	p2s_state_t        next_state;
	logic [DCNT_W-1:0] bit_cnt;
	logic [DCNT_W-1:0] next_bit_cnt;
	logic [CCNT_W-1:0] cyc_cnt;
	logic [DATA_BITS:0] buff; // one pad bit ahead of the data
	logic              fall_next;

	// s_clk falls on the next edge, so data moves one cycle before it
	assign fall_next = (cyc_cnt == CCNT_LAST) && s_clk;

	always_comb begin
		next_state   = state;
		next_bit_cnt = bit_cnt;
		case (state)
			P2S_IDLE: begin
				next_bit_cnt = '0;
				if (start) begin
					next_state = P2S_CLEAR;
				end
			end
			P2S_CLEAR: begin
				next_bit_cnt = '0;
				if (fall_next) begin
					next_state = P2S_WORK;
				end
			end
			P2S_WORK: begin
				if (fall_next) begin
					next_bit_cnt = bit_cnt + 1'b1;
					if (bit_cnt == DCNT_LAST) begin
						next_state = P2S_DONE;
					end
				end
			end
			P2S_DONE: begin
				next_state   = P2S_IDLE;
				next_bit_cnt = '0;
			end
			default: begin
				next_state = P2S_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= P2S_IDLE;
			bit_cnt <= '0;
		end else begin
			state   <= next_state;
			bit_cnt <= next_bit_cnt;
		end
	end

	// status outputs follow the state being entered
	always_ff @(posedge clk) begin
		if (rst) begin
			busy   <= 1'b0;
			finish <= 1'b0;
			s_clr  <= 1'b0;
		end else begin
			busy   <= (next_state == P2S_CLEAR) || (next_state == P2S_WORK);
			finish <= (next_state == P2S_DONE);
			s_clr  <= (next_state == P2S_CLEAR);
		end
	end

	// word is loaded throughout clear, pad bit leaves on the first fall
	always_ff @(posedge clk) begin
		case (next_state)
			P2S_IDLE, P2S_DONE: begin
				buff <= '0;
			end
			P2S_CLEAR: begin
				if (CODE_ENDIAN != 0) begin
					buff <= {1'b0, data};
				end else begin
					buff <= {data, 1'b0};
				end
			end
			P2S_WORK: begin
				if (fall_next) begin
					if (CODE_ENDIAN != 0) begin
						buff <= {buff[DATA_BITS-1:0], 1'b0};
					end else begin
						buff <= {1'b0, buff[DATA_BITS:1]};
					end
				end
			end
			default: begin
				buff <= '0;
			end
		endcase
	end

	assign s_dat = (CODE_ENDIAN != 0) ? buff[DATA_BITS] : buff[0];

	// serial clock, low whenever the engine is idle
	always_ff @(posedge clk) begin
		if (rst || state == P2S_IDLE || state == P2S_DONE) begin
			cyc_cnt <= '0;
			s_clk   <= 1'b0;
		end else if (cyc_cnt == CCNT_LAST) begin
			cyc_cnt <= '0;
			s_clk   <= ~s_clk;
		end else begin
			cyc_cnt <= cyc_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== logic/update_sequencer.sv ====
// pin update sequencer
`timescale 1ns/1ps
`default_nettype none
`include "expander_settings.svh"

module update_sequencer
	import expander_pkg::*;
(
	input  wire                       clk,
	input  wire                       rst,
	input  wire                       upd_valid,
	input  wire [`EXP_DATA_BITS-1:0]  upd_data,
	output logic                      upd_ready,
	output logic [`EXP_DATA_BITS-1:0] frame,
	output logic                      start,
	input  wire                       finish,
	output logic                      s_lat,
	output logic                      pending
);

	localparam int LAT_CYCLES = `EXP_LATCH_CYCLES;
	localparam int LAT_W      = $clog2(LAT_CYCLES + 1);
	localparam logic [LAT_W-1:0] LAT_LAST = LAT_W'(LAT_CYCLES - 1);

	seq_state_t       state;
	logic [LAT_W-1:0] lat_cnt; // cycles of latch pulse so far

	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= SEQ_IDLE;
			lat_cnt <= '0;
		end else begin
			case (state)
				SEQ_IDLE: begin
					if (upd_valid) begin
						state <= SEQ_START; // ready is high here
					end
				end
				SEQ_START: begin
					state <= SEQ_SHIFT;
				end
				SEQ_SHIFT: begin
					if (finish) begin
						state   <= SEQ_LATCH;
						lat_cnt <= '0;
					end
				end
				SEQ_LATCH: begin
					if (lat_cnt == LAT_LAST) begin
						state <= SEQ_IDLE;
					end else begin
						lat_cnt <= lat_cnt + 1'b1;
					end
				end
				default: begin
					state <= SEQ_IDLE;
				end
			endcase
		end
	end

	// snapshot held for the whole shift
	always_ff @(posedge clk) begin
		if (upd_valid && upd_ready) begin
			frame <= upd_data;
		end
	end

	assign upd_ready = (state == SEQ_IDLE);
	assign start     = (state == SEQ_START); // one cycle after hand-over
	assign s_lat     = (state == SEQ_LATCH); // s_clk is parked low by now
	assign pending   = (state != SEQ_IDLE) || upd_valid;

endmodule

`default_nettype wire

// ==== logic/shadow_register.sv ====
// shadow pin image
`timescale 1ns/1ps
`default_nettype none
`include "expander_settings.svh"

module shadow_register
	import expander_pkg::*;
(
	input  wire                       clk,
	input  wire                       rst,
	input  wire                       cmd_valid,
	input  wire exp_op_t              cmd_op,
	input  wire [`EXP_DATA_BITS-1:0]  cmd_arg,
	input  wire                       upd_ready,
	output logic                      upd_valid,
	output logic [`EXP_DATA_BITS-1:0] upd_data,
	output logic [`EXP_DATA_BITS-1:0] image
);

	localparam int W = `EXP_DATA_BITS;

	logic [W-1:0] image_q;
	logic [W-1:0] image_next;
	logic         dirty; // image not yet handed to the sequencer

	// result of the incoming command
	always_comb begin
		case (cmd_op)
			OP_WRITE: begin
				image_next = cmd_arg;
			end
			OP_SET: begin
				image_next = image_q | cmd_arg;
			end
			OP_CLEAR: begin
				image_next = image_q & ~cmd_arg;
			end
			OP_TOGGLE: begin
				image_next = image_q ^ cmd_arg;
			end
			default: begin
				image_next = image_q;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			image_q <= '0;
			dirty   <= 1'b0;
		end else begin
			if (cmd_valid) begin
				image_q <= image_next;
				dirty   <= 1'b1; // set even if no bit changed
			end else if (upd_valid && upd_ready) begin
				dirty   <= 1'b0; // handed over, nothing newer
			end
		end
	end

	// a command in the hand-over cycle keeps dirty high,
	// so later commands merge into one pending update
	assign upd_valid = dirty;
	assign upd_data  = image_q; // always the current image
	assign image     = image_q;

endmodule

`default_nettype wire

// ==== logic/expander_pkg.sv ====
// output expander types
`default_nettype none

package expander_pkg;

	// host command opcodes
	typedef enum logic [1:0] {
		OP_WRITE  = 2'd0, // image = arg
		OP_SET    = 2'd1, // image | mask
		OP_CLEAR  = 2'd2, // image & ~mask
		OP_TOGGLE = 2'd3  // image ^ mask
	} exp_op_t;

	// update sequencer states
	typedef enum logic [1:0] {
		SEQ_IDLE  = 2'd0,
		SEQ_START = 2'd1, // start pulse to engine
		SEQ_SHIFT = 2'd2, // waiting for finish
		SEQ_LATCH = 2'd3  // storage latch high
	} seq_state_t;

endpackage

`default_nettype wire

// ==== include/expander_settings.svh ====
// output expander build settings
`ifndef EXPANDER_SETTINGS_SVH
`define EXPANDER_SETTINGS_SVH

`define EXP_P_CLK_FREQ 100   // main clock, MHz
`define EXP_S_CLK_FREQ 10    // serial clock, MHz
`define EXP_DATA_BITS 32     // length of the external chain

// 0 sends bit 0 first, 1 sends the top bit first
`define EXP_CODE_ENDIAN 0

`define EXP_LATCH_CYCLES 5   // storage latch pulse, main clocks

`endif
